// ==== vlog.f ====
hw/cpu_pkg.sv
hw/instr_pkg.sv
hw/exec_stage.sv
hw/wb_queue.sv
hw/wb_stage.sv
hw/lar_file.sv
hw/wb_top.sv
test/wb_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert --timescale 1ns/100ps
LINT_FLAGS = --lint-only --timing --timescale 1ns/100ps
TOP = wb_tb
FILELIST = vlog.f
OBJ_DIR = obj_dir
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/wb_tb.sv ====
`timescale 1ns/100ps

module wb_tb;

	localparam int MEM_BYTES = 256;
	localparam int N_RANDOM = 2000;
	localparam int N_DIRECTED = 200;
	localparam int TIMEOUT_CYCLES = 200 * (N_RANDOM + N_DIRECTED) + 500;

	logic clk;
	logic rst_n;
	logic in_valid;
	instr_pkg::oper_e in_oper;
	cpu_pkg::reg_index_t in_ra;
	cpu_pkg::data_t in_opnd_a;
	cpu_pkg::data_t in_opnd_b;
	instr_pkg::simm12_t in_simm;
	logic stall;
	logic commit_valid;
	cpu_pkg::reg_index_t commit_index;
	cpu_pkg::data_t commit_data;
	cpu_pkg::write_type_e commit_write_type;

	// reference state of registers and memory
	cpu_pkg::data_t model_regs [16];
	logic [7:0] model_mem [MEM_BYTES];

	cpu_pkg::reg_index_t exp_index_q [$];
	cpu_pkg::data_t exp_data_q [$];
	cpu_pkg::write_type_e exp_type_q [$];

	cpu_pkg::reg_index_t chk_index;
	cpu_pkg::data_t chk_data;
	cpu_pkg::write_type_e chk_type;

	int errors;
	int commits;
	int expected_commits;
	logic stall_seen;
	logic [31:0] rng_state;

	instr_pkg::oper_e alu_ops [6] = '{instr_pkg::OpAdd, instr_pkg::OpSub, instr_pkg::OpAnd,
		instr_pkg::OpOr, instr_pkg::OpXor, instr_pkg::OpSyscall};
	instr_pkg::oper_e ld_ops [9] = '{instr_pkg::OpLdU8, instr_pkg::OpLdS8, instr_pkg::OpLdU16,
		instr_pkg::OpLdS16, instr_pkg::OpLdU32, instr_pkg::OpLdS32, instr_pkg::OpLdU64,
		instr_pkg::OpLdS64, instr_pkg::OpLdF16};

	wb_top DUT
	(
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_oper(in_oper),
		.in_ra(in_ra),
		.in_opnd_a(in_opnd_a),
		.in_opnd_b(in_opnd_b),
		.in_simm(in_simm),
		.stall(stall),
		.commit_valid(commit_valid),
		.commit_index(commit_index),
		.commit_data(commit_data),
		.commit_write_type(commit_write_type)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// expected commit of one instruction, updating the model; 0 when nothing commits
	function automatic logic model_step(input instr_pkg::oper_e op,
		input cpu_pkg::reg_index_t ra, input cpu_pkg::data_t a, input cpu_pkg::data_t b,
		input instr_pkg::simm12_t simm, output cpu_pkg::data_t exp_data,
		output cpu_pkg::write_type_e exp_type);
		cpu_pkg::data_t addr;
		cpu_pkg::data_t word;
		int base;
		int nbytes;
		int i;
		logic sgn;
		logic is_ld;
		model_step = 1'b1;
		exp_data = '0;
		exp_type = cpu_pkg::WriteTypOnlyData;
		addr = a + {{52{simm[11]}}, simm};
		base = int'(addr % 64'(MEM_BYTES));
		case (op)
		instr_pkg::OpAdd: exp_data = a + b;
		instr_pkg::OpSub: exp_data = a - b;
		instr_pkg::OpAnd: exp_data = a & b;
		instr_pkg::OpOr: exp_data = a | b;
		instr_pkg::OpXor: exp_data = a ^ b;
		instr_pkg::OpSyscall: model_step = 1'b0;
		default:
		begin
			case (op)
			instr_pkg::OpLdU8, instr_pkg::OpLdS8, instr_pkg::OpStU8, instr_pkg::OpStS8:
				nbytes = 1;
			instr_pkg::OpLdU16, instr_pkg::OpLdS16, instr_pkg::OpLdF16,
			instr_pkg::OpStU16, instr_pkg::OpStS16, instr_pkg::OpStF16:
				nbytes = 2;
			instr_pkg::OpLdU32, instr_pkg::OpLdS32, instr_pkg::OpStU32, instr_pkg::OpStS32:
				nbytes = 4;
			default:
				nbytes = 8;
			endcase
			sgn = (op == instr_pkg::OpLdS8) || (op == instr_pkg::OpLdS16)
				|| (op == instr_pkg::OpLdS32) || (op == instr_pkg::OpLdS64);
			is_ld = 1'b0;
			for (i = 0; i < 9; i++)
				if (op == ld_ops[i])
					is_ld = 1'b1;
			word = '0;
			if (is_ld)
			begin
				for (i = 0; i < nbytes; i++)
					word[8*i +: 8] = model_mem[(base + i) % MEM_BYTES];
				if (sgn && word[8*nbytes-1])
					for (i = 8 * nbytes; i < 64; i++)
						word[i] = 1'b1;
				model_regs[ra] = word;
				exp_type = cpu_pkg::WriteTypLd;
			end
			else
			begin
				// little-endian, low bytes of ra only
				for (i = 0; i < nbytes; i++)
				begin
					word[8*i +: 8] = model_regs[ra][8*i +: 8];
					model_mem[(base + i) % MEM_BYTES] = word[8*i +: 8];
				end
				exp_type = cpu_pkg::WriteTypSt;
			end
			exp_data = word;
		end
		endcase
		if (model_step && (exp_type == cpu_pkg::WriteTypOnlyData))
			model_regs[ra] = exp_data;
	endfunction

	// called just after a rising edge; returns one edge after the instruction is taken
	task automatic send(input instr_pkg::oper_e op, input cpu_pkg::reg_index_t ra,
		input cpu_pkg::data_t a, input cpu_pkg::data_t b, input instr_pkg::simm12_t simm);
		cpu_pkg::data_t exp_data;
		cpu_pkg::write_type_e exp_type;
		in_oper = op;
		in_ra = ra;
		in_opnd_a = a;
		in_opnd_b = b;
		in_simm = simm;
		in_valid = 1'b1;
		while (stall)
		begin
			@(posedge clk);
			#0.5;
		end
		if (model_step(op, ra, a, b, simm, exp_data, exp_type))
		begin
			exp_index_q.push_back(ra);
			exp_data_q.push_back(exp_data);
			exp_type_q.push_back(exp_type);
			expected_commits++;
		end
		@(posedge clk);
		#0.5;
		in_valid = 1'b0;
	endtask

	task automatic set_reg(input cpu_pkg::reg_index_t ra, input cpu_pkg::data_t value);
		send(instr_pkg::OpAdd, ra, value, 64'd0, 12'sd0);
	endtask

	task automatic mem_op(input instr_pkg::oper_e op, input cpu_pkg::reg_index_t ra,
		input cpu_pkg::data_t addr);
		send(op, ra, addr, 64'd0, 12'sd0);
	endtask

	task automatic random_instr(input logic ldst_only);
		instr_pkg::oper_e op;
		cpu_pkg::data_t a;
		if (ldst_only)
			op = instr_pkg::oper_e'(5'(6 + next_rand() % 18));
		else
			op = instr_pkg::oper_e'(5'(next_rand() % 24));
		if (op >= instr_pkg::OpLdU8)
			a = 64'(16 + next_rand() % (MEM_BYTES - 32));
		else
			a = {next_rand(), next_rand()};
		send(op, 4'(next_rand()), a, {next_rand(), next_rand()},
			instr_pkg::simm12_t'(int'(next_rand() % 32) - 16));
	endtask

	// commits are sampled away from the rising edge
	always @(negedge clk)
	begin
		if (rst_n && stall)
			stall_seen = 1'b1;
		if (rst_n && commit_valid)
		begin
			commits++;
			assert (exp_index_q.size() != 0)
			else
			begin
				errors++;
				$display("commit at %0t arrived with no instruction waiting for one", $time);
			end
			if (exp_index_q.size() != 0)
			begin
				chk_index = exp_index_q.pop_front();
				chk_data = exp_data_q.pop_front();
				chk_type = exp_type_q.pop_front();
				assert (commit_index == chk_index)
				else
				begin
					errors++;
					$display("Error at %0t: commit_index expected %0d got %0d",
						$time, chk_index, commit_index);
				end
				assert (commit_data == chk_data)
				else
				begin
					errors++;
					$display("Error at %0t: commit_data expected %h got %h",
						$time, chk_data, commit_data);
				end
				assert (commit_write_type == chk_type)
				else
				begin
					errors++;
					$display("Error at %0t: commit_write_type expected %0d got %0d",
						$time, chk_type, commit_write_type);
				end
			end
		end
	end

	initial
	begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("timeout: commits did not drain within %0d cycles", TIMEOUT_CYCLES);
		$display("sim failed");
		$finish;
	end

	initial
	begin
		int n;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_oper = instr_pkg::OpAdd;
		in_ra = '0;
		in_opnd_a = '0;
		in_opnd_b = '0;
		in_simm = '0;
		errors = 0;
		commits = 0;
		expected_commits = 0;
		stall_seen = 1'b0;
		rng_state = 32'h782f7be8;
		for (n = 0; n < 16; n++)
			model_regs[n] = '0;
		for (n = 0; n < MEM_BYTES; n++)
			model_mem[n] = '0;
		repeat (16) @(posedge clk);
		#0.5;
		rst_n = 1'b1;
		@(posedge clk);
		#0.5;

		// every ALU operation, then a few more syscalls
		for (n = 0; n < 6; n++)
			send(alu_ops[n], 4'(n), {next_rand(), next_rand()}, {next_rand(), next_rand()}, 0);
		for (n = 0; n < 3; n++)
			send(instr_pkg::OpSyscall, 4'(n + 8), 64'd1, 64'd2, 12'sd0);

		// negative and positive patterns through every load form
		set_reg(3, 64'h8c7f_e5a1_96b3_f0d2);
		mem_op(instr_pkg::OpStS64, 3, 64'h40);
		for (n = 0; n < 9; n++)
			mem_op(ld_ops[n], 4'(4 + n), 64'h40);
		set_reg(3, 64'h1234_5678_1a2b_3c4d);
		mem_op(instr_pkg::OpStU64, 3, 64'h48);
		for (n = 0; n < 9; n++)
			mem_op(ld_ops[n], 4'(4 + n), 64'h48);

		// narrow stores touch only their own bytes
		set_reg(5, 64'h0102_0304_0506_0708);
		mem_op(instr_pkg::OpStU64, 5, 64'h80);
		set_reg(6, 64'hf9fa_fbfc_fdfe_ffee);
		mem_op(instr_pkg::OpStU8, 6, 64'h80);
		mem_op(instr_pkg::OpLdU64, 7, 64'h80);
		mem_op(instr_pkg::OpStS16, 6, 64'h82);
		mem_op(instr_pkg::OpLdU64, 7, 64'h80);
		mem_op(instr_pkg::OpStF16, 6, 64'h86);
		mem_op(instr_pkg::OpLdU64, 7, 64'h80);
		mem_op(instr_pkg::OpStS32, 6, 64'h84);
		mem_op(instr_pkg::OpLdU64, 7, 64'h80);

		// accesses that wrap past the end of memory
		mem_op(instr_pkg::OpStU64, 5, 64'(MEM_BYTES - 3));
		mem_op(instr_pkg::OpLdU64, 8, 64'(MEM_BYTES - 3));
		send(instr_pkg::OpLdU32, 9, 64'd1, 64'd0, -12'sd1);
		mem_op(instr_pkg::OpLdU8, 10, 64'(MEM_BYTES + 1));

		// back-to-back memory traffic
		stall_seen = 1'b0;
		for (n = 0; n < 48; n++)
			random_instr(1'b1);
		assert (stall_seen)
		else
		begin
			errors++;
			$display("stall never rose during a long run of loads and stores");
		end

		for (n = 0; n < N_RANDOM; n++)
		begin
			random_instr(1'b0);
			if (next_rand() % 4 == 0)
			begin
				@(posedge clk);
				#0.5;
			end
		end

		while (exp_index_q.size() != 0)
			@(posedge clk);
		// room for any commit that should not appear
		repeat (20) @(posedge clk);
		assert (commits == expected_commits)
		else
		begin
			errors++;
			$display("commit count %0d does not match %0d accepted writing instructions",
				commits, expected_commits);
		end

		$display("errors: %0d, commits: %0d, expected commits: %0d",
			errors, commits, expected_commits);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// ==== hw/wb_top.sv ====
`timescale 1ns/100ps

module wb_top
#(
	parameter int QUEUE_DEPTH = 4,
	parameter int LDST_LATENCY = 3,
	parameter int MEM_BYTES = 256
)
(
	input  logic clk,
	input  logic rst_n,
	input  logic in_valid,
	input  instr_pkg::oper_e in_oper,
	input  cpu_pkg::reg_index_t in_ra,
	input  cpu_pkg::data_t in_opnd_a,
	input  cpu_pkg::data_t in_opnd_b,
	input  instr_pkg::simm12_t in_simm,
	output logic stall,
	output logic commit_valid,
	output cpu_pkg::reg_index_t commit_index,
	output cpu_pkg::data_t commit_data,
	output cpu_pkg::write_type_e commit_write_type
);

	// execute to queue
	logic ex_valid;
	instr_pkg::group_t ex_group;
	instr_pkg::oper_e ex_oper;
	cpu_pkg::reg_index_t ex_ra;
	cpu_pkg::data_t ex_result;
	cpu_pkg::addr_t ex_addr;

	// queue head to writeback
	logic q_valid;
	logic q_pop;
	instr_pkg::group_t q_group;
	instr_pkg::oper_e q_oper;
	cpu_pkg::reg_index_t q_ra;
	cpu_pkg::data_t q_result;
	cpu_pkg::addr_t q_addr;

	// writeback requests into the lar file
	logic wr_req;
	logic ldst_valid;
	cpu_pkg::write_type_e wr_write_type;
	cpu_pkg::reg_index_t wr_index;
	cpu_pkg::data_t wr_data;
	cpu_pkg::addr_t wr_addr;
	cpu_pkg::data_type_e wr_data_type;
	cpu_pkg::int_size_e wr_int_size;

	exec_stage u_exec_stage (.*);

	wb_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_wb_queue (.*);

	wb_stage u_wb_stage (.*);

	lar_file #(.LDST_LATENCY(LDST_LATENCY), .MEM_BYTES(MEM_BYTES)) u_lar_file (.*);

endmodule

// ==== hw/lar_file.sv ====
`timescale 1ns/100ps

module lar_file
#(
	parameter int LDST_LATENCY = 3,
	parameter int MEM_BYTES = 256
)
(
	input  logic clk,
	input  logic rst_n,
	input  logic wr_req,
	input  cpu_pkg::write_type_e wr_write_type,
	input  cpu_pkg::reg_index_t wr_index,
	input  cpu_pkg::data_t wr_data,
	input  cpu_pkg::addr_t wr_addr,
	input  cpu_pkg::data_type_e wr_data_type,
	input  cpu_pkg::int_size_e wr_int_size,
	output logic ldst_valid,
	output logic commit_valid,
	output cpu_pkg::reg_index_t commit_index,
	output cpu_pkg::data_t commit_data,
	output cpu_pkg::write_type_e commit_write_type
);

	localparam int MEM_AW = $clog2(MEM_BYTES);
	localparam int CNT_W = (LDST_LATENCY > 1) ? $clog2(LDST_LATENCY) : 1;

	cpu_pkg::data_t regs [cpu_pkg::REG_COUNT];
	logic [7:0] mem [MEM_BYTES];

	logic busy;
	logic [CNT_W-1:0] cnt;
	logic done;
	cpu_pkg::write_type_e pend_type;
	cpu_pkg::reg_index_t pend_index;
	logic [MEM_AW-1:0] pend_offset;
	cpu_pkg::data_type_e pend_dtype;
	cpu_pkg::int_size_e pend_size;
	logic alu_valid;
	cpu_pkg::data_t alu_data;
	cpu_pkg::data_t raw_word;
	cpu_pkg::int_size_e ld_size;
	cpu_pkg::data_t ld_value;
	cpu_pkg::data_t st_value;

	function automatic cpu_pkg::data_t extend(input cpu_pkg::data_t v,
		input cpu_pkg::int_size_e sz, input logic sgn);
		case (sz)
		cpu_pkg::IntTypSz8: extend = {{56{sgn & v[7]}}, v[7:0]};
		cpu_pkg::IntTypSz16: extend = {{48{sgn & v[15]}}, v[15:0]};
		cpu_pkg::IntTypSz32: extend = {{32{sgn & v[31]}}, v[31:0]};
		default: extend = v;
		endcase
	endfunction

	// little-endian gather, wrapping at the end of memory
	always_comb
	begin
		for (int i = 0; i < 8; i++)
			raw_word[8*i +: 8] = mem[pend_offset + MEM_AW'(i)];
	end

	// bfloat16 is just the raw 16 bits
	assign ld_size = (pend_dtype == cpu_pkg::DataTypBFloat16) ? cpu_pkg::IntTypSz16 : pend_size;
	assign ld_value = extend(raw_word, ld_size, pend_dtype == cpu_pkg::DataTypSgnInt);
	assign st_value = extend(regs[pend_index], pend_size, 1'b0);

	assign done = busy && (cnt == '0);
	assign ldst_valid = done;
	assign commit_valid = alu_valid || done;
	assign commit_index = pend_index;
	assign commit_data = done
		? ((pend_type == cpu_pkg::WriteTypSt) ? st_value : ld_value)
		: alu_data;
	assign commit_write_type = done ? pend_type : cpu_pkg::WriteTypOnlyData;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy <= 1'b0;
			cnt <= '0;
			alu_valid <= 1'b0;
		end
		else
		begin
			alu_valid <= wr_req && (wr_write_type == cpu_pkg::WriteTypOnlyData);
			if (wr_req && (wr_write_type != cpu_pkg::WriteTypOnlyData))
			begin
				busy <= 1'b1;
				cnt <= CNT_W'(LDST_LATENCY - 1);
			end
			else if (done)
				busy <= 1'b0;
			else if (busy)
				cnt <= cnt - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_req)
		begin
			pend_type <= wr_write_type;
			pend_index <= wr_index;
			pend_offset <= wr_addr[MEM_AW-1:0];
			pend_dtype <= wr_data_type;
			pend_size <= wr_int_size;
			alu_data <= wr_data;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int r = 0; r < cpu_pkg::REG_COUNT; r++)
				regs[r] <= '0;
			for (int b = 0; b < MEM_BYTES; b++)
				mem[b] <= '0;
		end
		else
		begin
			if (wr_req && (wr_write_type == cpu_pkg::WriteTypOnlyData))
				regs[wr_index] <= wr_data;
			if (done && (pend_type == cpu_pkg::WriteTypLd))
				regs[pend_index] <= ld_value;
			// only the low size bytes of ra
			if (done && (pend_type == cpu_pkg::WriteTypSt))
				for (int i = 0; i < 8; i++)
					if (i < (1 << pend_size))
						mem[pend_offset + MEM_AW'(i)] <= st_value[8*i +: 8];
		end
	end

endmodule

// ==== hw/wb_stage.sv ====
`timescale 1ns/100ps

module wb_stage
(
	input  logic clk,
	input  logic rst_n,
	input  logic q_valid,
	input  instr_pkg::group_t q_group,
	input  instr_pkg::oper_e q_oper,
	input  cpu_pkg::reg_index_t q_ra,
	input  cpu_pkg::data_t q_result,
	input  cpu_pkg::addr_t q_addr,
	input  logic ldst_valid,
	output logic q_pop,
	output logic wr_req,
	output cpu_pkg::write_type_e wr_write_type,
	output cpu_pkg::reg_index_t wr_index,
	output cpu_pkg::data_t wr_data,
	output cpu_pkg::addr_t wr_addr,
	output cpu_pkg::data_type_e wr_data_type,
	output cpu_pkg::int_size_e wr_int_size
);

	typedef enum logic
	{
		StRegular,
		StWaitLdst
	} state_e;

	state_e state;
	state_e next_state;
	logic is_ldst;
	logic is_write;

	assign is_ldst = (q_group == instr_pkg::GROUP_LD)
		|| (q_group == instr_pkg::GROUP_ST);

	// syscall and the unused group write nothing
	assign is_write = is_ldst
		|| ((q_group == instr_pkg::GROUP_ALU) && (q_oper != instr_pkg::OpSyscall));

	// nothing leaves the queue while a memory access is outstanding
	assign q_pop = (state == StRegular) && q_valid;

	always_comb
	begin
		next_state = state;
		case (state)
		StRegular:
		begin
			if (q_pop && is_ldst)
				next_state = StWaitLdst;
		end
		StWaitLdst:
		begin
			if (ldst_valid)
				next_state = StRegular;
		end
		default:
		begin
			next_state = StRegular;
		end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= StRegular;
			wr_req <= 1'b0;
		end
		else
		begin
			state <= next_state;
			wr_req <= q_pop && is_write;
		end
	end

	// request fields for the entry just popped
	always_ff @(posedge clk)
	begin
		if (q_pop)
		begin
			wr_index <= q_ra;
			wr_data <= q_result;
			wr_addr <= q_addr;
			wr_data_type <= instr_pkg::type_of(q_oper);
			wr_int_size <= instr_pkg::size_of(q_oper);
			case (q_group)
			instr_pkg::GROUP_LD: wr_write_type <= cpu_pkg::WriteTypLd;
			instr_pkg::GROUP_ST: wr_write_type <= cpu_pkg::WriteTypSt;
			default: wr_write_type <= cpu_pkg::WriteTypOnlyData;
			endcase
		end
	end

endmodule

// ==== hw/wb_queue.sv ====
`timescale 1ns/100ps

module wb_queue
#(
	parameter int QUEUE_DEPTH = 4
)
(
	input  logic clk,
	input  logic rst_n,
	input  logic ex_valid,
	input  instr_pkg::group_t ex_group,
	input  instr_pkg::oper_e ex_oper,
	input  cpu_pkg::reg_index_t ex_ra,
	input  cpu_pkg::data_t ex_result,
	input  cpu_pkg::addr_t ex_addr,
	input  logic q_pop,
	output logic q_valid,
	output instr_pkg::group_t q_group,
	output instr_pkg::oper_e q_oper,
	output cpu_pkg::reg_index_t q_ra,
	output cpu_pkg::data_t q_result,
	output cpu_pkg::addr_t q_addr,
	output logic stall
);

	localparam int PTR_W = $clog2(QUEUE_DEPTH);
	localparam int CNT_W = PTR_W + 1;

	instr_pkg::group_t group_mem [QUEUE_DEPTH];
	instr_pkg::oper_e oper_mem [QUEUE_DEPTH];
	cpu_pkg::reg_index_t ra_mem [QUEUE_DEPTH];
	cpu_pkg::data_t result_mem [QUEUE_DEPTH];
	cpu_pkg::addr_t addr_mem [QUEUE_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	assign q_valid = (count != '0);
	assign q_group = group_mem[rd_ptr];
	assign q_oper = oper_mem[rd_ptr];
	assign q_ra = ra_mem[rd_ptr];
	assign q_result = result_mem[rd_ptr];
	assign q_addr = addr_mem[rd_ptr];

	// leave a slot for the instruction one cycle behind in exec_stage
	assign stall = (int'(count) + int'(ex_valid)) >= QUEUE_DEPTH;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (ex_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (q_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({ex_valid, q_pop})
			2'b10: count <= count + 1'b1;
			2'b01: count <= count - 1'b1;
			default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (ex_valid)
		begin
			group_mem[wr_ptr] <= ex_group;
			oper_mem[wr_ptr] <= ex_oper;
			ra_mem[wr_ptr] <= ex_ra;
			result_mem[wr_ptr] <= ex_result;
			addr_mem[wr_ptr] <= ex_addr;
		end
	end

endmodule

// ==== hw/exec_stage.sv ====
`timescale 1ns/100ps

module exec_stage
(
	input  logic clk,
	input  logic rst_n,
	input  logic in_valid,
	input  logic stall,
	input  instr_pkg::oper_e in_oper,
	input  cpu_pkg::reg_index_t in_ra,
	input  cpu_pkg::data_t in_opnd_a,
	input  cpu_pkg::data_t in_opnd_b,
	input  instr_pkg::simm12_t in_simm,
	output logic ex_valid,
	output instr_pkg::group_t ex_group,
	output instr_pkg::oper_e ex_oper,
	output cpu_pkg::reg_index_t ex_ra,
	output cpu_pkg::data_t ex_result,
	output cpu_pkg::addr_t ex_addr
);

	localparam int SIMM_W = $bits(instr_pkg::simm12_t);

	logic take;
	cpu_pkg::data_t alu_result;
	cpu_pkg::addr_t eff_addr;

	// source holds the instruction while stall is high
	assign take = in_valid && !stall;

	always_comb
	begin
		case (in_oper)
		instr_pkg::OpAdd: alu_result = in_opnd_a + in_opnd_b;
		instr_pkg::OpSub: alu_result = in_opnd_a - in_opnd_b;
		instr_pkg::OpAnd: alu_result = in_opnd_a & in_opnd_b;
		instr_pkg::OpOr: alu_result = in_opnd_a | in_opnd_b;
		instr_pkg::OpXor: alu_result = in_opnd_a ^ in_opnd_b;
		// syscall, loads and stores
		default: alu_result = '0;
		endcase
	end

	// base plus sign-extended immediate
	assign eff_addr = in_opnd_a
		+ {{(cpu_pkg::ADDR_WIDTH - SIMM_W){in_simm[SIMM_W-1]}}, in_simm};

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ex_valid <= 1'b0;
		end
		else
		begin
			ex_valid <= take;
		end
	end

	always_ff @(posedge clk)
	begin
		if (take)
		begin
			ex_group <= instr_pkg::group_of(in_oper);
			ex_oper <= in_oper;
			ex_ra <= in_ra;
			ex_result <= alu_result;
			ex_addr <= eff_addr;
		end
	end

endmodule

// ==== hw/instr_pkg.sv ====
package instr_pkg;

	// loads and stores share one ordering of sizes
	typedef enum logic [4:0]
	{
		OpAdd, OpSub, OpAnd, OpOr, OpXor, OpSyscall,
		OpLdU8, OpLdS8, OpLdU16, OpLdS16, OpLdU32, OpLdS32, OpLdU64, OpLdS64, OpLdF16,
		OpStU8, OpStS8, OpStU16, OpStS16, OpStU32, OpStS32, OpStU64, OpStS64, OpStF16
	} oper_e;

	typedef logic signed [11:0] simm12_t;

	typedef logic [1:0] group_t;
	localparam group_t GROUP_ALU = 2'd0;
	localparam group_t GROUP_LD = 2'd2;
	localparam group_t GROUP_ST = 2'd3;

	localparam logic [4:0] LD_TO_ST = 5'(OpStU8 - OpLdU8);

	function automatic group_t group_of(input oper_e op);
		if ((op >= OpLdU8) && (op <= OpLdF16))
			group_of = GROUP_LD;
		else if ((op >= OpStU8) && (op <= OpStF16))
			group_of = GROUP_ST;
		else
			group_of = GROUP_ALU;
	endfunction

	// store mapped onto the load with the same size and type
	function automatic oper_e ld_form(input oper_e op);
		if (group_of(op) == GROUP_ST)
			ld_form = oper_e'(op - LD_TO_ST);
		else
			ld_form = op;
	endfunction

	function automatic cpu_pkg::int_size_e size_of(input oper_e op);
		case (ld_form(op))
		OpLdU8, OpLdS8: size_of = cpu_pkg::IntTypSz8;
		OpLdU16, OpLdS16, OpLdF16: size_of = cpu_pkg::IntTypSz16;
		OpLdU32, OpLdS32: size_of = cpu_pkg::IntTypSz32;
		default: size_of = cpu_pkg::IntTypSz64;
		endcase
	endfunction

	function automatic cpu_pkg::data_type_e type_of(input oper_e op);
		case (ld_form(op))
		OpLdS8, OpLdS16, OpLdS32, OpLdS64: type_of = cpu_pkg::DataTypSgnInt;
		OpLdF16: type_of = cpu_pkg::DataTypBFloat16;
		default: type_of = cpu_pkg::DataTypUnsgnInt;
		endcase
	endfunction

endpackage

// ==== hw/cpu_pkg.sv ====
package cpu_pkg;

	// datapath widths
	localparam int DATA_WIDTH = 64;
	localparam int ADDR_WIDTH = 64;
	localparam int REG_INDEX_WIDTH = 4;
	localparam int REG_COUNT = 1 << REG_INDEX_WIDTH;

	typedef logic [DATA_WIDTH-1:0] data_t;
	typedef logic [ADDR_WIDTH-1:0] addr_t;

	// register 0 is not hardwired to zero
	typedef logic [REG_INDEX_WIDTH-1:0] reg_index_t;

	typedef enum logic [1:0]
	{
		DataTypUnsgnInt,
		DataTypSgnInt,
		DataTypBFloat16
	} data_type_e;

	// value is log2 of the byte count
	typedef enum logic [1:0]
	{
		IntTypSz8,
		IntTypSz16,
		IntTypSz32,
		IntTypSz64
	} int_size_e;

	// what a lar file write request does
	typedef enum logic [1:0]
	{
		WriteTypOnlyData,
		WriteTypLd,
		WriteTypSt
	} write_type_e;

endpackage
